//--- Bender.yml
package:
  name: sd_spi_ctrl

export_include_dirs:
  - hw

sources:
  - hw/sd_pkg.sv
  - hw/spi_byte_if.sv
  - hw/sd_req_if.sv
  - hw/spi_byte_engine.sv
  - hw/sd_cmd_unit.sv
  - hw/sd_ctrl_fsm.sv
  - hw/sd_spi_ctrl.sv
  - target: test
    files:
      - verif/sd_card_model.sv
      - verif/sd_spi_ctrl_assert.sv
      - verif/sd_spi_ctrl_tb.sv

//--- all.f
+incdir+hw
hw/sd_pkg.sv
hw/spi_byte_if.sv
hw/sd_req_if.sv
hw/spi_byte_engine.sv
hw/sd_cmd_unit.sv
hw/sd_ctrl_fsm.sv
hw/sd_spi_ctrl.sv
verif/sd_card_model.sv
verif/sd_spi_ctrl_assert.sv
verif/sd_spi_ctrl_tb.sv

//--- hw/sd_cmd_unit.sv
// SD command unit that sends six-byte command frames, polls for R1 and passes raw bytes
`include "sd_consts.svh"

module sd_cmd_unit (
    input  logic       clk,
    input  logic       rst_n,
    sd_req_if.slave    req,
    spi_byte_if.master byte_if
);

    localparam int poll_w = $clog2(`SD_RESP_TIMEOUT + 1);

    typedef enum logic [1:0] {
        cu_idle,
        cu_frame,
        cu_poll,
        cu_raw
    } cu_state_e;

    cu_state_e         state;
    // Argument and CRC bytes still to send
    logic [39:0]       frame;
    logic [2:0]        byte_idx;
    logic [poll_w-1:0] poll_cnt;

    function automatic sd_pkg::sd_byte_t crc_for(sd_pkg::sd_cmd_e c);
        case (c)
            sd_pkg::op_cmd0: return 8'h95;
            sd_pkg::op_cmd8: return 8'h87;
            default:         return 8'h01;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= cu_idle;
            frame         <= '1;
            byte_idx      <= '0;
            poll_cnt      <= '0;
            byte_if.start <= 1'b0;
            byte_if.tx    <= `SD_IDLE_BYTE;
            req.done      <= 1'b0;
            req.rx        <= `SD_IDLE_BYTE;
            req.timeout   <= 1'b0;
        end else begin
            byte_if.start <= 1'b0;
            req.done      <= 1'b0;
            case (state)
                cu_idle: begin
                    if (req.cmd_start) begin
                        frame         <= {req.arg, crc_for(req.cmd)};
                        byte_if.tx    <= {2'b01, req.cmd};
                        byte_if.start <= 1'b1;
                        byte_idx      <= '0;
                        state         <= cu_frame;
                    end else if (req.raw_start) begin
                        byte_if.tx    <= req.raw_tx;
                        byte_if.start <= 1'b1;
                        state         <= cu_raw;
                    end
                end
                cu_frame: begin
                    if (byte_if.done) begin
                        // After the CRC the shifted-in FF becomes the first poll byte
                        byte_if.tx    <= frame[39:32];
                        byte_if.start <= 1'b1;
                        frame         <= {frame[31:0], `SD_IDLE_BYTE};
                        byte_idx      <= byte_idx + 1'b1;
                        if (byte_idx == 3'd5) begin
                            poll_cnt <= '0;
                            state    <= cu_poll;
                        end
                    end
                end
                cu_poll: begin
                    if (byte_if.done) begin
                        if (byte_if.rx != `SD_IDLE_BYTE ||
                            poll_cnt == poll_w'(`SD_RESP_TIMEOUT - 1)) begin
                            req.done    <= 1'b1;
                            req.rx      <= byte_if.rx;
                            req.timeout <= (byte_if.rx == `SD_IDLE_BYTE);
                            state       <= cu_idle;
                        end else begin
                            poll_cnt      <= poll_cnt + 1'b1;
                            byte_if.start <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (byte_if.done) begin
                        req.done    <= 1'b1;
                        req.rx      <= byte_if.rx;
                        req.timeout <= 1'b0;
                        state       <= cu_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/sd_consts.svh
// SD SPI controller constants for timing, block size, tokens and limits
`ifndef SD_CONSTS_SVH
`define SD_CONSTS_SVH

// --------------------
// Timing
// --------------------
// clk cycles per SPI clock half period
`define SD_CLK_DIV        5
// Dummy bytes sent with chip select high
`define SD_POWERUP_BYTES  80

// --------------------
// Block geometry
// --------------------
`define SD_BLOCK_BYTES    64
`define SD_BLOCK_BITS     512

// --------------------
// Limits
// --------------------
// FF bytes polled before an R1 timeout
`define SD_RESP_TIMEOUT   1000
`define SD_TOKEN_TIMEOUT  1024
`define SD_ACMD41_MAX     2000

// --------------------
// Bus bytes and tokens
// --------------------
`define SD_START_TOKEN    8'hFE
`define SD_IDLE_BYTE      8'hFF
// Low five bits of the data response
`define SD_DATA_ACCEPTED  5'h05

`endif

//--- hw/sd_ctrl_fsm.sv
// SD control sequencer for power-up, card initialization, block read and block write
`include "sd_consts.svh"

module sd_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    sd_req_if.master                  req,
    input  logic [`SD_BLOCK_BITS-1:0] write_data,
    input  logic                      write_data_ready,
    output logic [`SD_BLOCK_BITS-1:0] read_data,
    output logic                      read_ready,
    output logic                      ready,
    output logic                      error,
    output logic                      spi_cs_n
);

    localparam int cnt_w  = $clog2(`SD_TOKEN_TIMEOUT + 1);
    localparam int acmd_w = $clog2(`SD_ACMD41_MAX + 1);

    sd_pkg::sd_state_e         state;
    logic                      pending;
    logic [cnt_w-1:0]          cnt;
    logic [acmd_w-1:0]         acmd_cnt;
    logic                      v2;
    sd_pkg::sd_byte_t          r7_prev;
    logic [31:0]               addr;
    logic [`SD_BLOCK_BITS-1:0] wr_buf;
    logic                      use_cmd;

    assign ready    = (state == sd_pkg::st_wr_wait);
    assign error    = (state == sd_pkg::st_error);
    assign spi_cs_n = (state == sd_pkg::st_powerup) || error;

    // --------------------
    // Request contents per state
    // --------------------
    always_comb begin
        use_cmd    = 1'b1;
        req.cmd    = sd_pkg::op_cmd0;
        req.arg    = '0;
        req.raw_tx = `SD_IDLE_BYTE;
        case (state)
            sd_pkg::st_cmd0:   req.cmd = sd_pkg::op_cmd0;
            sd_pkg::st_cmd8: begin
                req.cmd = sd_pkg::op_cmd8;
                req.arg = 32'h0000_01AA;
            end
            sd_pkg::st_cmd55:  req.cmd = sd_pkg::op_cmd55;
            sd_pkg::st_acmd41: begin
                // HCS bit for version-2 cards
                req.cmd = sd_pkg::op_acmd41;
                req.arg = {1'b0, v2, 30'd0};
            end
            sd_pkg::st_cmd16: begin
                req.cmd = sd_pkg::op_cmd16;
                req.arg = `SD_BLOCK_BYTES;
            end
            sd_pkg::st_rd_cmd: begin
                req.cmd = sd_pkg::op_cmd17;
                req.arg = addr;
            end
            sd_pkg::st_wr_cmd: begin
                req.cmd = sd_pkg::op_cmd24;
                req.arg = addr;
            end
            sd_pkg::st_wr_token: begin
                use_cmd    = 1'b0;
                req.raw_tx = `SD_START_TOKEN;
            end
            sd_pkg::st_wr_data: begin
                use_cmd    = 1'b0;
                req.raw_tx = wr_buf[`SD_BLOCK_BITS-1 -: 8];
            end
            default: use_cmd = 1'b0;
        endcase
    end

    // --------------------
    // Sequencer
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= sd_pkg::st_powerup;
            pending       <= 1'b0;
            cnt           <= '0;
            acmd_cnt      <= '0;
            v2            <= 1'b0;
            r7_prev       <= '0;
            addr          <= '0;
            read_ready    <= 1'b0;
            req.cmd_start <= 1'b0;
            req.raw_start <= 1'b0;
        end else begin
            req.cmd_start <= 1'b0;
            req.raw_start <= 1'b0;
            read_ready    <= 1'b0;
            if (!pending && !ready && !error) begin
                pending       <= 1'b1;
                req.cmd_start <= use_cmd;
                req.raw_start <= !use_cmd;
            end
            if (ready && write_data_ready) begin
                state <= sd_pkg::st_wr_cmd;
            end
            if (req.done) begin
                pending <= 1'b0;
                cnt     <= cnt + 1'b1;
                case (state)
                    sd_pkg::st_powerup: begin
                        if (cnt == cnt_w'(`SD_POWERUP_BYTES - 1)) begin
                            cnt   <= '0;
                            state <= sd_pkg::st_cmd0;
                        end
                    end
                    sd_pkg::st_cmd0: begin
                        state <= (req.rx == 8'h01) ? sd_pkg::st_cmd8 : sd_pkg::st_error;
                    end
                    sd_pkg::st_cmd8: begin
                        cnt   <= '0;
                        state <= (req.rx == 8'h01) ? sd_pkg::st_r7_tail : sd_pkg::st_error;
                    end
                    sd_pkg::st_r7_tail: begin
                        r7_prev <= req.rx;
                        if (cnt == cnt_w'(3)) begin
                            v2    <= ({r7_prev, req.rx} == 16'h01AA);
                            state <= sd_pkg::st_cmd55;
                        end
                    end
                    sd_pkg::st_cmd55: begin
                        state <= (req.rx[7:1] == '0) ? sd_pkg::st_acmd41 : sd_pkg::st_error;
                    end
                    sd_pkg::st_acmd41: begin
                        acmd_cnt <= acmd_cnt + 1'b1;
                        if (req.rx == 8'h00) begin
                            state <= sd_pkg::st_cmd16;
                        end else if (req.rx == 8'h01 &&
                                     acmd_cnt != acmd_w'(`SD_ACMD41_MAX - 1)) begin
                            state <= sd_pkg::st_cmd55;
                        end else begin
                            state <= sd_pkg::st_error;
                        end
                    end
                    sd_pkg::st_cmd16, sd_pkg::st_rd_cmd, sd_pkg::st_wr_cmd: begin
                        cnt <= '0;
                        if (req.rx != 8'h00) begin
                            state <= sd_pkg::st_error;
                        end else if (state == sd_pkg::st_wr_cmd) begin
                            state <= sd_pkg::st_wr_token;
                        end else begin
                            state <= (state == sd_pkg::st_cmd16) ? sd_pkg::st_rd_cmd
                                                                 : sd_pkg::st_rd_token;
                        end
                    end
                    sd_pkg::st_rd_token: begin
                        if (req.rx == `SD_START_TOKEN) begin
                            cnt   <= '0;
                            state <= sd_pkg::st_rd_data;
                        end else if (cnt == cnt_w'(`SD_TOKEN_TIMEOUT - 1)) begin
                            state <= sd_pkg::st_error;
                        end
                    end
                    sd_pkg::st_rd_data: begin
                        if (cnt == cnt_w'(`SD_BLOCK_BYTES - 1)) begin
                            read_ready <= 1'b1;
                            state      <= sd_pkg::st_wr_wait;
                        end
                    end
                    sd_pkg::st_wr_token: begin
                        cnt   <= '0;
                        state <= sd_pkg::st_wr_data;
                    end
                    sd_pkg::st_wr_data: begin
                        if (cnt == cnt_w'(`SD_BLOCK_BYTES - 1)) begin
                            cnt   <= '0;
                            state <= sd_pkg::st_wr_resp;
                        end
                    end
                    sd_pkg::st_wr_resp: begin
                        if (req.rx != `SD_IDLE_BYTE) begin
                            state <= (req.rx[4:0] == `SD_DATA_ACCEPTED) ? sd_pkg::st_wr_busy
                                                                        : sd_pkg::st_error;
                        end else if (cnt == cnt_w'(`SD_RESP_TIMEOUT - 1)) begin
                            state <= sd_pkg::st_error;
                        end
                    end
                    sd_pkg::st_wr_busy: begin
                        // Card holds MISO low while programming
                        if (req.rx == `SD_IDLE_BYTE) begin
                            addr  <= addr + `SD_BLOCK_BYTES;
                            state <= sd_pkg::st_rd_cmd;
                        end
                    end
                    default: state <= sd_pkg::st_error;
                endcase
                if (use_cmd && req.timeout) begin
                    state <= sd_pkg::st_error;
                end
            end
        end
    end

    // Block buffers with the MSB byte first on the wire
    always_ff @(posedge clk) begin
        if (ready && write_data_ready) begin
            wr_buf <= write_data;
        end else if (state == sd_pkg::st_wr_data && req.done) begin
            wr_buf <= {wr_buf[`SD_BLOCK_BITS-9:0], 8'h00};
        end
        if (state == sd_pkg::st_rd_data && req.done) begin
            read_data <= {read_data[`SD_BLOCK_BITS-9:0], req.rx};
        end
    end

endmodule

//--- hw/sd_pkg.sv
// SD SPI controller shared types for bus bytes, command opcodes and sequencer states
package sd_pkg;

    typedef logic [7:0] sd_byte_t;

    // Opcode value is the command index
    typedef enum logic [5:0] {
        op_cmd0   = 6'd0,
        op_cmd8   = 6'd8,
        op_cmd16  = 6'd16,
        op_cmd17  = 6'd17,
        op_cmd24  = 6'd24,
        op_acmd41 = 6'd41,
        op_cmd55  = 6'd55
    } sd_cmd_e;

    typedef enum logic [4:0] {
        st_powerup,
        st_cmd0,
        st_cmd8,
        st_r7_tail,
        st_cmd55,
        st_acmd41,
        st_cmd16,
        st_rd_cmd,
        st_rd_token,
        st_rd_data,
        st_wr_wait,
        st_wr_cmd,
        st_wr_token,
        st_wr_data,
        st_wr_resp,
        st_wr_busy,
        st_error
    } sd_state_e;

endpackage

//--- hw/sd_req_if.sv
// Request link between the control sequencer and the command unit
interface sd_req_if;

    // Command frame request
    logic             cmd_start;
    sd_pkg::sd_cmd_e  cmd;
    logic [31:0]      arg;
    // Single raw byte request
    logic             raw_start;
    sd_pkg::sd_byte_t raw_tx;
    // Completion
    logic             done;
    sd_pkg::sd_byte_t rx;
    logic             timeout;

    modport master (
        output cmd_start, cmd, arg, raw_start, raw_tx,
        input  done, rx, timeout
    );

    modport slave (
        input  cmd_start, cmd, arg, raw_start, raw_tx,
        output done, rx, timeout
    );

endinterface

//--- hw/sd_spi_ctrl.sv
// SD card controller top in SPI mode with 64-byte block read and write-back
`include "sd_consts.svh"

module sd_spi_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`SD_BLOCK_BITS-1:0] write_data,
    input  logic                      write_data_ready,
    output logic [`SD_BLOCK_BITS-1:0] read_data,
    output logic                      read_ready,
    output logic                      ready,
    output logic                      error,
    output logic                      spi_clk,
    output logic                      spi_cs_n,
    output logic                      spi_mosi,
    input  logic                      spi_miso
);

    spi_byte_if u_byte_if ();
    sd_req_if   u_req_if ();

    // --------------------
    // Sequencer
    // --------------------
    sd_ctrl_fsm u_ctrl_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .req              (u_req_if.master),
        .write_data       (write_data),
        .write_data_ready (write_data_ready),
        .read_data        (read_data),
        .read_ready       (read_ready),
        .ready            (ready),
        .error            (error),
        .spi_cs_n         (spi_cs_n)
    );

    sd_cmd_unit u_cmd_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (u_req_if.slave),
        .byte_if (u_byte_if.master)
    );

    // SPI pins
    spi_byte_engine u_byte_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .byte_if  (u_byte_if.slave),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

endmodule

//--- hw/spi_byte_engine.sv
// SPI byte engine with a clock divider and a mode-0 shifter for single bytes
`include "sd_consts.svh"

module spi_byte_engine (
    input  logic      clk,
    input  logic      rst_n,
    spi_byte_if.slave byte_if,
    output logic      spi_clk,
    output logic      spi_mosi,
    input  logic      spi_miso
);

    localparam int div_w = $clog2(`SD_CLK_DIV + 1);
    localparam logic [div_w-1:0] div_last = div_w'(`SD_CLK_DIV - 1);

    logic [div_w-1:0] div_cnt;
    // Sixteen SPI clock edges per byte
    logic [3:0]       edge_cnt;
    logic             busy;
    logic             tick;
    sd_pkg::sd_byte_t tx_sr;
    sd_pkg::sd_byte_t rx_sr;

    assign tick     = busy && (div_cnt == div_last);
    assign spi_mosi = tx_sr[7];
    assign byte_if.rx = rx_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            div_cnt      <= '0;
            edge_cnt     <= '0;
            spi_clk      <= 1'b0;
            tx_sr        <= `SD_IDLE_BYTE;
            byte_if.done <= 1'b0;
        end else begin
            byte_if.done <= 1'b0;
            if (byte_if.start && !busy) begin
                busy     <= 1'b1;
                div_cnt  <= '0;
                edge_cnt <= '0;
                tx_sr    <= byte_if.tx;
            end else if (busy) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    spi_clk  <= ~spi_clk;
                    edge_cnt <= edge_cnt + 1'b1;
                    // Falling edge shifts the next bit out with idle high behind it
                    if (spi_clk) begin
                        tx_sr <= {tx_sr[6:0], 1'b1};
                        if (edge_cnt == 4'd15) begin
                            busy         <= 1'b0;
                            byte_if.done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Sample on rising edge
    always_ff @(posedge clk) begin
        if (tick && !spi_clk) begin
            rx_sr <= {rx_sr[6:0], spi_miso};
        end
    end

endmodule

//--- hw/spi_byte_if.sv
// SPI byte link between the command unit and the byte engine
interface spi_byte_if;

    logic             start;
    sd_pkg::sd_byte_t tx;
    sd_pkg::sd_byte_t rx;
    logic             done;

    modport master (
        output start, tx,
        input  rx, done
    );

    modport slave (
        input  start, tx,
        output rx, done
    );

endinterface

//--- verif/sd_card_model.sv
// Behavioral SPI-mode SD card, version 2, with a small byte-addressed block memory
`include "sd_consts.svh"

module sd_card_model (
    input  logic spi_clk,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic spi_miso
);

    localparam int mem_bytes = 512;

    logic [7:0]  mem [mem_bytes];
    logic        mute;
    logic        hcs_seen;
    logic        card_idle;
    int          acmd41_cnt;
    logic [7:0]  in_sr;
    logic [7:0]  out_sr;
    int          bit_cnt;
    logic        byte_end;
    logic [7:0]  cmd_buf [6];
    int          cmd_idx;
    // 0 command, 1 waiting for start token, 2 write data
    int          mode;
    int          data_idx;
    logic [31:0] wr_addr;
    logic [7:0]  resp_q [$];

    assign spi_miso = spi_cs_n ? 1'b1 : out_sr[7];

    initial begin
        for (int a = 0; a < mem_bytes; a++) begin
            mem[a] = 8'(a * 3);
        end
        mute       = 1'b0;
        hcs_seen   = 1'b0;
        card_idle  = 1'b1;
        acmd41_cnt = 0;
        out_sr     = `SD_IDLE_BYTE;
        bit_cnt    = 0;
        byte_end   = 1'b0;
        cmd_idx    = 0;
        mode       = 0;
    end

    task automatic run_cmd();
        logic [5:0]  idx;
        logic [31:0] arg;
        idx = cmd_buf[0][5:0];
        arg = {cmd_buf[1], cmd_buf[2], cmd_buf[3], cmd_buf[4]};
        if (mute) return;
        // One byte of NCR before the R1
        resp_q.push_back(`SD_IDLE_BYTE);
        case (idx)
            6'd0:  resp_q.push_back(8'h01);
            6'd8:  resp_q = {resp_q, 8'h01, 8'h00, 8'h00, 8'h01, 8'hAA};
            6'd55: resp_q.push_back({7'd0, card_idle});
            6'd41: begin
                hcs_seen = arg[30];
                if (acmd41_cnt >= 3) card_idle = 1'b0;
                acmd41_cnt++;
                resp_q.push_back({7'd0, card_idle});
            end
            6'd16: resp_q.push_back(8'h00);
            6'd17: begin
                resp_q = {resp_q, 8'h00, `SD_IDLE_BYTE, `SD_START_TOKEN};
                for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
                    resp_q.push_back(mem[(int'(arg) + i) % mem_bytes]);
                end
            end
            6'd24: begin
                resp_q.push_back(8'h00);
                wr_addr = arg;
                mode    = 1;
            end
            default: resp_q.push_back(8'h04);
        endcase
    endtask

    task automatic take_byte(input logic [7:0] b);
        case (mode)
            1: begin
                if (b == `SD_START_TOKEN) begin
                    mode     = 2;
                    data_idx = 0;
                end
            end
            2: begin
                mem[(int'(wr_addr) + data_idx) % mem_bytes] = b;
                data_idx++;
                if (data_idx == `SD_BLOCK_BYTES) begin
                    mode   = 0;
                    // Data accepted, then busy for a few bytes
                    resp_q = {resp_q, 8'h05, 8'h00, 8'h00, 8'h00, 8'h00};
                end
            end
            default: begin
                if (cmd_idx > 0 || b[7:6] == 2'b01) begin
                    cmd_buf[cmd_idx] = b;
                    cmd_idx++;
                    if (cmd_idx == 6) begin
                        cmd_idx = 0;
                        run_cmd();
                    end
                end
            end
        endcase
    endtask

    always @(posedge spi_cs_n) begin
        resp_q.delete();
        bit_cnt  = 0;
        byte_end = 1'b0;
        cmd_idx  = 0;
        mode     = 0;
        out_sr   = `SD_IDLE_BYTE;
    end

    always @(posedge spi_clk) begin
        if (!spi_cs_n) begin
            in_sr = {in_sr[6:0], spi_mosi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt  = 0;
                byte_end = 1'b1;
                take_byte(in_sr);
            end
        end
    end

    // Next byte is loaded on the last falling edge of the current one
    always @(negedge spi_clk) begin
        if (!spi_cs_n) begin
            if (byte_end) begin
                byte_end = 1'b0;
                out_sr   = (resp_q.size() > 0) ? resp_q.pop_front() : `SD_IDLE_BYTE;
            end else begin
                out_sr = {out_sr[6:0], 1'b1};
            end
        end
    end

endmodule

//--- verif/sd_spi_ctrl_assert.sv
// Protocol assertions for the SD SPI controller top level outputs
module sd_spi_ctrl_assert (
    input logic clk,
    input logic rst_n,
    input logic read_ready,
    input logic ready,
    input logic error,
    input logic spi_cs_n
);

    a_read_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        read_ready |=> !read_ready)
        else $error("read_ready high in two consecutive cycles");

    a_ready_not_error: assert property (@(posedge clk) !(ready && error))
        else $error("ready and error high together");

    a_cs_in_reset: assert property (@(posedge clk) !rst_n |-> spi_cs_n)
        else $error("spi_cs_n low while reset is held");

    // Sticky error
    a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        error |=> error)
        else $error("error dropped without reset");

endmodule

bind sd_spi_ctrl sd_spi_ctrl_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .read_ready (read_ready),
    .ready      (ready),
    .error      (error),
    .spi_cs_n   (spi_cs_n)
);

//--- verif/sd_spi_ctrl_tb.sv
// Testbench for the SD SPI controller with a behavioral card and a block table
`include "sd_consts.svh"

module sd_spi_ctrl_tb;

    localparam int rows        = 4;
    localparam int byte_cycles = 16 * `SD_CLK_DIV;
    localparam longint wd_cycles = 2 * byte_cycles *
        (rows * 2 * 75 + 75 + 2 * `SD_POWERUP_BYTES + 200 + `SD_RESP_TIMEOUT);

    logic                      clk;
    logic                      rst_n;
    logic [`SD_BLOCK_BITS-1:0] write_data;
    logic                      write_data_ready;
    logic [`SD_BLOCK_BITS-1:0] read_data;
    logic                      read_ready;
    logic                      ready;
    logic                      error;
    logic                      spi_clk;
    logic                      spi_cs_n;
    logic                      spi_mosi;
    logic                      spi_miso;

    logic [`SD_BLOCK_BITS-1:0] wr_tab [rows];
    logic [`SD_BLOCK_BITS-1:0] rd_tab [rows];
    logic [31:0]               lfsr;
    int                        errors;
    int                        checks;
    logic                      in_write;
    logic                      mute_phase;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    sd_spi_ctrl u_sd_spi_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .write_data       (write_data),
        .write_data_ready (write_data_ready),
        .read_data        (read_data),
        .read_ready       (read_ready),
        .ready            (ready),
        .error            (error),
        .spi_clk          (spi_clk),
        .spi_cs_n         (spi_cs_n),
        .spi_mosi         (spi_mosi),
        .spi_miso         (spi_miso)
    );

    sd_card_model u_card (
        .spi_clk  (spi_clk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Card preload rule with byte address a holding the low byte of a*3
    function automatic logic [`SD_BLOCK_BITS-1:0] preload_block(input int a);
        logic [`SD_BLOCK_BITS-1:0] blk;
        for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
            blk[`SD_BLOCK_BITS-1-8*i -: 8] = 8'((a + i) * 3);
        end
        return blk;
    endfunction

    function automatic logic [`SD_BLOCK_BITS-1:0] card_block(input int a);
        logic [`SD_BLOCK_BITS-1:0] blk;
        for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
            blk[`SD_BLOCK_BITS-1-8*i -: 8] = u_card.mem[(a + i) % 512];
        end
        return blk;
    endfunction

    task automatic check_val(input string name, input logic [`SD_BLOCK_BITS-1:0] got,
                             input logic [`SD_BLOCK_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic build_table();
        lfsr = 32'h10d1f8eb;
        for (int r = 0; r < rows; r++) begin
            for (int b = 0; b < `SD_BLOCK_BITS; b++) begin
                lfsr         = lfsr_next(lfsr);
                wr_tab[r][b] = lfsr[0];
            end
            rd_tab[r] = preload_block(r * `SD_BLOCK_BYTES);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #10 rst_n = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_val("spi_cs_n", spi_cs_n, 1'b1);
            check_val("spi_clk", spi_clk, 1'b0);
        end
        @(posedge clk);
        #10 rst_n = 1'b1;
    endtask

    task automatic wait_read_ready();
        do @(negedge clk); while (!read_ready);
        in_write = 1'b0;
    endtask

    // ready must stay low between write acceptance and the next read
    always @(negedge clk) begin
        if (in_write && ready && !read_ready) begin
            errors++;
            $display("[FAIL] %0t ready got 1 expected 0", $time);
        end
        if (mute_phase && (ready || read_ready)) begin
            errors++;
            $display("Unresponsive card at %0t, but ready or read_ready went high", $time);
        end
    end

    initial begin
        #(wd_cycles * 100);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int cnt;
        rst_n            = 1'b0;
        write_data       = '0;
        write_data_ready = 1'b0;
        errors           = 0;
        checks           = 0;
        in_write         = 1'b0;
        mute_phase       = 1'b0;
        build_table();
        apply_reset();

        // --------------------
        // Read and write back
        // --------------------
        wait_read_ready();
        check_val("error", error, 1'b0);
        check_val("hcs_seen", u_card.hcs_seen, 1'b1);
        for (int r = 0; r < rows; r++) begin
            check_val("read_data", read_data, rd_tab[r]);
            check_val("ready", ready, 1'b1);
            @(posedge clk);
            #10;
            write_data       = wr_tab[r];
            write_data_ready = 1'b1;
            do @(negedge clk); while (ready);
            in_write = 1'b1;
            @(posedge clk);
            #10 write_data_ready = 1'b0;
            wait_read_ready();
            check_val("card block", card_block(r * `SD_BLOCK_BYTES), wr_tab[r]);
        end
        check_val("read_data", read_data, preload_block(rows * `SD_BLOCK_BYTES));

        // --------------------
        // Unresponsive card
        // --------------------
        u_card.mute = 1'b1;
        apply_reset();
        mute_phase = 1'b1;
        cnt = 0;
        while (!error && cnt < 2 * byte_cycles * (`SD_POWERUP_BYTES + 20 + `SD_RESP_TIMEOUT)) begin
            @(negedge clk);
            cnt++;
        end
        mute_phase = 1'b0;
        checks++;
        if (!error) begin
            errors++;
            $display("error never rose with an unresponsive card");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
